/* list.f */
logic/rv_pkg.sv
logic/trap_if.sv
logic/lsu_align.sv
logic/control_unit.sv
logic/machine_trap_unit.sv
logic/core_ctrl_top.sv
sim/tb_core_ctrl.sv

/* Makefile */
SRCS := $(wildcard logic/*.sv) $(wildcard sim/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_core_ctrl: list.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_core_ctrl -f list.f -o Vtb_core_ctrl

sim.log: obj_dir/Vtb_core_ctrl
	-./obj_dir/Vtb_core_ctrl > sim.log 2>&1

run: sim.log
	@cat sim.log
	@if grep -F -q '*** FAILED ***' sim.log; then \
		echo "simulation failed"; rm -f sim.log; exit 1; \
	fi
	@grep -F -q '*** PASSED ***' sim.log || (rm -f sim.log; exit 1)
	@rm -f sim.log

clean:
	rm -rf obj_dir sim.log

/* sim/tb_core_ctrl.sv */
`default_nettype none

module tb_core_ctrl;
    timeunit 1ns;
    timeprecision 1ps;

    logic                    clk;
    logic                    rst_n;
    logic [31:0]             inst;
    logic                    take_branch;
    logic [rv_pkg::xlen-1:0] next_pc;
    logic [rv_pkg::xlen-1:0] dmem_addr;
    logic [rv_pkg::xlen-1:0] csr_wdata;
    logic                    imem_ready;
    logic                    dmem_ready;
    logic [rv_pkg::xlen-1:0] pc;
    logic                    inst_read;
    logic                    data_read;
    logic                    data_write;
    logic                    reg_write;
    logic [3:0]              byte_en;
    logic [rv_pkg::xlen-1:0] csr_rdata;

    // Stimulus table, one entry per instruction
    string                   names[$];
    logic [31:0]             t_inst[$];
    logic [rv_pkg::xlen-1:0] t_next_pc[$];
    logic                    t_take[$];
    logic [rv_pkg::xlen-1:0] t_daddr[$];
    logic [rv_pkg::xlen-1:0] t_wdata[$];
    logic [rv_pkg::xlen-1:0] t_exp_pc[$];
    logic [3:0]              t_exp_be[$];
    bit                      t_chk_be[$];
    logic [rv_pkg::xlen-1:0] t_exp_csr[$];
    bit                      t_chk_csr[$];
    int                      t_exp_rw[$];
    // Data access kind, 0 none, 1 read, 2 write
    int                      t_exp_data[$];

    int reg_write_cycles;
    int read_cycles;
    int write_cycles;
    int cycles;
    int cycle_limit;
    int iwait;
    int dwait;

    core_ctrl_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst        (inst),
        .take_branch (take_branch),
        .next_pc     (next_pc),
        .dmem_addr   (dmem_addr),
        .csr_wdata   (csr_wdata),
        .imem_ready  (imem_ready),
        .dmem_ready  (dmem_ready),
        .pc          (pc),
        .inst_read   (inst_read),
        .data_read   (data_read),
        .data_write  (data_write),
        .reg_write   (reg_write),
        .byte_en     (byte_en),
        .csr_rdata   (csr_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_run();
        $display("*** FAILED ***");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_pc(string name, logic [rv_pkg::xlen-1:0] exp,
                            logic [rv_pkg::xlen-1:0] act);
        if (act !== exp) begin
            $display("** Error %s: pc expected %h, actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_byte_en(string name, logic [3:0] exp, logic [3:0] act);
        if (act !== exp) begin
            $display("** Error %s: byte_en expected %b, actual %b", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_csr(string name, logic [rv_pkg::xlen-1:0] exp,
                             logic [rv_pkg::xlen-1:0] act);
        if (act !== exp) begin
            $display("** Error %s: csr_rdata expected %h, actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_count(string name, string what, int exp, int act);
        if (act != exp) begin
            $display("** Error %s: %s expected %0d, actual %0d", name, what, exp, act);
            stop_run();
        end
    endtask

    task automatic add_row(string name, logic [31:0] i, logic [31:0] npc, logic tk,
                           logic [31:0] da, logic [31:0] wd, logic [31:0] epc,
                           logic [3:0] ebe, bit cbe, logic [31:0] ecsr, bit ccsr,
                           int erw, int edata);
        names.push_back(name);
        t_inst.push_back(i);
        t_next_pc.push_back(npc);
        t_take.push_back(tk);
        t_daddr.push_back(da);
        t_wdata.push_back(wd);
        t_exp_pc.push_back(epc);
        t_exp_be.push_back(ebe);
        t_chk_be.push_back(cbe);
        t_exp_csr.push_back(ecsr);
        t_chk_csr.push_back(ccsr);
        t_exp_rw.push_back(erw);
        t_exp_data.push_back(edata);
    endtask

    // Memory model, ready after a random wait of 0 to 3 cycles
    always @(negedge clk) begin
        if (!rst_n) begin
            imem_ready = 1'b0;
            dmem_ready = 1'b0;
        end else begin
            if (imem_ready) begin
                imem_ready = 1'b0;
                iwait = $urandom % 4;
            end else if (inst_read) begin
                if (iwait == 0) imem_ready = 1'b1;
                else iwait = iwait - 1;
            end
            if (dmem_ready) begin
                dmem_ready = 1'b0;
                dwait = $urandom % 4;
            end else if (data_read || data_write) begin
                if (dwait == 0) dmem_ready = 1'b1;
                else dwait = dwait - 1;
            end
        end
    end

    // Strobe monitor and watchdog
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (reg_write) reg_write_cycles = reg_write_cycles + 1;
        if (data_read) read_cycles = read_cycles + 1;
        if (data_write) write_cycles = write_cycles + 1;
        if (reg_write && data_read) begin
            $display("reg_write was raised while the load was still waiting for data");
            stop_run();
        end
        if (cycles > cycle_limit) begin
            $display("Timeout: the core stopped advancing after %0d cycles", cycles);
            stop_run();
        end
    end

    initial begin
        int k;
        void'($urandom(43));
        iwait       = $urandom % 4;
        dwait       = $urandom % 4;
        cycles      = 0;
        cycle_limit = 1000;
        rst_n       = 1'b0;
        inst        = 32'h0000_0013;
        take_branch = 1'b0;
        next_pc     = '0;
        dmem_addr   = '0;
        csr_wdata   = '0;
        imem_ready  = 1'b0;
        dmem_ready  = 1'b0;
        reg_write_cycles = 0;
        read_cycles      = 0;
        write_cycles     = 0;

        add_row("op_add", 32'h003100B3, 32'h104, 0, 32'h0, 32'h0, 32'h104, 4'h0, 0, 0, 0, 1, 0);
        add_row("lb", 32'h00010083, 32'h108, 0, 32'h1003, 0, 32'h108, 4'b1000, 1, 0, 0, 1, 1);
        add_row("lh", 32'h00011083, 32'h10C, 0, 32'h1002, 0, 32'h10C, 4'b1100, 1, 0, 0, 1, 1);
        add_row("lw", 32'h00012083, 32'h110, 0, 32'h1004, 0, 32'h110, 4'b1111, 1, 0, 0, 1, 1);
        add_row("sb", 32'h00000023, 32'h114, 0, 32'h2001, 0, 32'h114, 4'b0010, 1, 0, 0, 0, 2);
        add_row("sh", 32'h00001023, 32'h118, 0, 32'h2000, 0, 32'h118, 4'b0011, 1, 0, 0, 0, 2);
        add_row("sw", 32'h00002023, 32'h11C, 0, 32'h2008, 0, 32'h11C, 4'b1111, 1, 0, 0, 0, 2);
        add_row("csrw_mtvec", 32'h30509073, 32'h120, 0, 0, 32'h803, 32'h120, 0, 0, 0, 1, 1, 0);
        add_row("csrr_mtvec", 32'h30502073, 32'h124, 0, 0, 32'h803, 32'h124, 0, 0,
                32'h803, 1, 1, 0);
        add_row("ecall", 32'h00000073, 32'h128, 0, 0, 0, 32'h800, 0, 0, 0, 0, 0, 0);
        add_row("mcause_ecall", 32'h34202073, 32'h804, 0, 0, 32'd11, 32'h804, 0, 0,
                32'd11, 1, 1, 0);
        add_row("mepc_ecall", 32'h34102073, 32'h808, 0, 0, 32'h124, 32'h808, 0, 0,
                32'h124, 1, 1, 0);
        add_row("mret", 32'h30200073, 32'h80C, 0, 0, 0, 32'h124, 0, 0, 0, 0, 0, 0);
        add_row("ebreak", 32'h00100073, 32'h128, 0, 0, 0, 32'h800, 0, 0, 0, 0, 0, 0);
        add_row("mcause_ebreak", 32'h34202073, 32'h804, 0, 0, 32'd3, 32'h804, 0, 0,
                32'd3, 1, 1, 0);
        add_row("illegal_op", 32'h0000007F, 32'h808, 0, 0, 0, 32'h800, 0, 0, 0, 0, 0, 0);
        add_row("mcause_illegal", 32'h34202073, 32'h804, 0, 0, 32'd2, 32'h804, 0, 0,
                32'd2, 1, 1, 0);
        add_row("mepc_illegal", 32'h34102073, 32'h808, 0, 0, 32'h804, 32'h808, 0, 0,
                32'h804, 1, 1, 0);
        add_row("jal_misalign", 32'h0000006F, 32'h906, 0, 0, 0, 32'h800, 0, 0, 0, 0, 0, 0);
        add_row("mcause_jal", 32'h34202073, 32'h804, 0, 0, 32'd0, 32'h804, 0, 0,
                32'd0, 1, 1, 0);
        add_row("lw_misalign", 32'h00012083, 32'h808, 0, 32'h3002, 0, 32'h800, 4'b0000, 1,
                0, 0, 0, 0);
        add_row("mcause_load", 32'h34202073, 32'h804, 0, 0, 32'd4, 32'h804, 0, 0,
                32'd4, 1, 1, 0);
        add_row("sh_misalign", 32'h00001023, 32'h808, 0, 32'h3001, 0, 32'h800, 4'b0000, 1,
                0, 0, 0, 0);
        add_row("mcause_store", 32'h34202073, 32'h804, 0, 0, 32'd6, 32'h804, 0, 0,
                32'd6, 1, 1, 0);
        add_row("beq_not_taken", 32'h00000063, 32'h80A, 0, 0, 0, 32'h80A, 0, 0, 0, 0, 0, 0);
        add_row("op_after", 32'h003100B3, 32'h810, 0, 0, 0, 32'h810, 0, 0, 0, 0, 1, 0);

        // Worst case per row is fetch wait, data wait, WB and TRAP
        cycle_limit = names.size() * (3 + 2 * 3 + 2) + 4;

        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        // First row is presented together with the reset release
        for (k = 0; k < names.size(); k++) begin
            inst        = t_inst[k];
            next_pc     = t_next_pc[k];
            take_branch = t_take[k];
            dmem_addr   = t_daddr[k];
            csr_wdata   = t_wdata[k];
            reg_write_cycles = 0;
            read_cycles      = 0;
            write_cycles     = 0;
            #1;
            if (k == 0) begin
                check_pc("reset", rv_pkg::reset_vector, pc);
                check_count("reset", "inst_read", 1, int'(inst_read));
            end
            // CSR value as left by the earlier rows
            if (t_chk_csr[k]) check_csr(names[k], t_exp_csr[k], csr_rdata);
            do @(negedge clk); while (inst_read);
            while (!inst_read) @(negedge clk);
            check_pc(names[k], t_exp_pc[k], pc);
            if (t_chk_be[k]) check_byte_en(names[k], t_exp_be[k], byte_en);
            check_count(names[k], "reg_write cycles", t_exp_rw[k], reg_write_cycles);
            check_count(names[k], "data access", t_exp_data[k],
                        (read_cycles > 0 ? 1 : 0) + (write_cycles > 0 ? 2 : 0));
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/core_ctrl_top.sv */
`default_nettype none

module core_ctrl_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [31:0]             inst,
    input  logic                    take_branch,
    input  logic [rv_pkg::xlen-1:0] next_pc,
    input  logic [rv_pkg::xlen-1:0] dmem_addr,
    input  logic [rv_pkg::xlen-1:0] csr_wdata,
    input  logic                    imem_ready,
    input  logic                    dmem_ready,
    output logic [rv_pkg::xlen-1:0] pc,
    output logic                    inst_read,
    output logic                    data_read,
    output logic                    data_write,
    output logic                    reg_write,
    output logic [3:0]              byte_en,
    output logic [rv_pkg::xlen-1:0] csr_rdata
);

    logic pc_write;
    logic csr_write;
    logic dmem_addr_misalign;

    trap_if trap_bus ();

    control_unit control_unit_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .inst               (inst),
        .take_branch        (take_branch),
        .next_pc            (next_pc),
        .dmem_addr_misalign (dmem_addr_misalign),
        .imem_ready         (imem_ready),
        .dmem_ready         (dmem_ready),
        .trap               (trap_bus.source),
        .pc_write           (pc_write),
        .inst_read          (inst_read),
        .data_read          (data_read),
        .data_write         (data_write),
        .reg_write          (reg_write),
        .csr_write          (csr_write)
    );

    // Access size is funct3[1:0] of the load or store
    lsu_align lsu_align_i (
        .addr     (dmem_addr),
        .size     (rv_pkg::mem_size_e'(inst[13:12])),
        .misalign (dmem_addr_misalign),
        .byte_en  (byte_en)
    );

    machine_trap_unit machine_trap_unit_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .pc_write   (pc_write),
        .next_pc    (next_pc),
        .fault_addr (dmem_addr),
        .csr_write  (csr_write),
        .csr_addr   (rv_pkg::csr_addr_e'(inst[31:20])),
        .csr_wdata  (csr_wdata),
        .trap       (trap_bus.sink),
        .pc         (pc),
        .csr_rdata  (csr_rdata)
    );

endmodule

`default_nettype wire

/* logic/machine_trap_unit.sv */
`default_nettype none

module machine_trap_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    pc_write,
    input  logic [rv_pkg::xlen-1:0] next_pc,
    input  logic [rv_pkg::xlen-1:0] fault_addr,
    input  logic                    csr_write,
    input  rv_pkg::csr_addr_e       csr_addr,
    input  logic [rv_pkg::xlen-1:0] csr_wdata,
    trap_if.sink                    trap,
    output logic [rv_pkg::xlen-1:0] pc,
    output logic [rv_pkg::xlen-1:0] csr_rdata
);

    rv_pkg::trap_cause_e     cause;
    logic [rv_pkg::xlen-1:0] tval;

    logic [rv_pkg::xlen-1:0] mtvec;
    logic [rv_pkg::xlen-1:0] mepc;
    logic [rv_pkg::xlen-1:0] mcause;
    logic [rv_pkg::xlen-1:0] mtval;

    assign trap.trap_pending = trap.inst_addr_misalign
                             | trap.illegal_inst
                             | trap.env_break
                             | trap.env_call
                             | trap.load_addr_misalign
                             | trap.store_addr_misalign;

    // Highest priority first
    always_comb begin
        cause = rv_pkg::ILLEGAL;
        tval  = '0;
        if (trap.inst_addr_misalign) begin
            cause = rv_pkg::INST_MISALIGN;
            tval  = next_pc;
        end else if (trap.illegal_inst) begin
            cause = rv_pkg::ILLEGAL;
        end else if (trap.env_break) begin
            cause = rv_pkg::BREAKPOINT;
        end else if (trap.env_call) begin
            cause = rv_pkg::ECALL_M;
        end else if (trap.load_addr_misalign) begin
            cause = rv_pkg::LOAD_MISALIGN;
            tval  = fault_addr;
        end else if (trap.store_addr_misalign) begin
            cause = rv_pkg::STORE_MISALIGN;
            tval  = fault_addr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= rv_pkg::reset_vector;
        end else if (pc_write) begin
            if (trap.trap_start) begin
                pc <= {mtvec[rv_pkg::xlen-1:2], 2'b00};
            end else if (trap.trap_finish) begin
                pc <= mepc;
            end else begin
                pc <= next_pc;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec  <= '0;
            mepc   <= '0;
            mcause <= '0;
            mtval  <= '0;
        end else begin
            // Cause and value are latched while the flags are still valid
            if (trap.trap_pending) begin
                mcause <= {{(rv_pkg::xlen - 4){1'b0}}, cause};
                mtval  <= tval;
            end
            if (pc_write && trap.trap_start) begin
                mepc <= pc;
            end
            if (csr_write) begin
                case (csr_addr)
                    rv_pkg::MTVEC:  mtvec  <= csr_wdata;
                    rv_pkg::MEPC:   mepc   <= csr_wdata;
                    rv_pkg::MCAUSE: mcause <= csr_wdata;
                    rv_pkg::MTVAL:  mtval  <= csr_wdata;
                    default: mtvec <= mtvec;
                endcase
            end
        end
    end

    always_comb begin
        case (csr_addr)
            rv_pkg::MTVEC:  csr_rdata = mtvec;
            rv_pkg::MEPC:   csr_rdata = mepc;
            rv_pkg::MCAUSE: csr_rdata = mcause;
            rv_pkg::MTVAL:  csr_rdata = mtval;
            default:        csr_rdata = '0;
        endcase
    end

    a_start_without_pending: assert property (@(posedge clk) disable iff (!rst_n)
        trap.trap_start |-> !trap.trap_pending)
        else $error("trap_start overlaps a new exception flag");

endmodule

`default_nettype wire

/* logic/control_unit.sv */
`default_nettype none

module control_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [31:0]             inst,
    input  logic                    take_branch,
    input  logic [rv_pkg::xlen-1:0] next_pc,
    input  logic                    dmem_addr_misalign,
    input  logic                    imem_ready,
    input  logic                    dmem_ready,
    trap_if.source                  trap,
    output logic                    pc_write,
    output logic                    inst_read,
    output logic                    data_read,
    output logic                    data_write,
    output logic                    reg_write,
    output logic                    csr_write
);

    rv_pkg::opcode_e     opcode;
    rv_pkg::sys_func_e   sys_func;
    rv_pkg::ctrl_state_e state;
    rv_pkg::ctrl_state_e state_nxt;
    logic [2:0]          funct3;

    // Requests before trap masking
    logic pc_wr_req;
    logic data_rd_req;
    logic data_wr_req;
    logic reg_wr_req;
    logic csr_wr_req;

    assign opcode   = rv_pkg::opcode_e'(inst[6:0]);
    assign sys_func = rv_pkg::sys_func_e'(inst[31:20]);
    assign funct3   = inst[14:12];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= rv_pkg::FETCH;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        inst_read   = 1'b0;
        pc_wr_req   = 1'b0;
        data_rd_req = 1'b0;
        data_wr_req = 1'b0;
        reg_wr_req  = 1'b0;
        csr_wr_req  = 1'b0;

        trap.trap_start          = 1'b0;
        trap.trap_finish         = 1'b0;
        trap.illegal_inst        = 1'b0;
        trap.inst_addr_misalign  = 1'b0;
        trap.load_addr_misalign  = 1'b0;
        trap.store_addr_misalign = 1'b0;
        trap.env_call            = 1'b0;
        trap.env_break           = 1'b0;

        case (state)
            rv_pkg::FETCH: inst_read = 1'b1;

            rv_pkg::EXECUTE: begin
                case (opcode)
                    rv_pkg::LUI, rv_pkg::AUIPC, rv_pkg::OP_IMM, rv_pkg::OP: begin
                        pc_wr_req  = 1'b1;
                        reg_wr_req = 1'b1;
                    end
                    rv_pkg::JAL: begin
                        pc_wr_req  = 1'b1;
                        reg_wr_req = 1'b1;
                        trap.inst_addr_misalign = next_pc[1:0] != 2'b00;
                    end
                    rv_pkg::JALR: begin
                        pc_wr_req  = 1'b1;
                        reg_wr_req = 1'b1;
                        // Bit 0 is cleared by the datapath
                        trap.inst_addr_misalign = next_pc[1];
                    end
                    rv_pkg::BRANCH: begin
                        pc_wr_req = 1'b1;
                        trap.inst_addr_misalign = take_branch && next_pc[1:0] != 2'b00;
                    end
                    rv_pkg::FENCE: pc_wr_req = 1'b1;
                    rv_pkg::LOAD: begin
                        data_rd_req = 1'b1;
                        trap.load_addr_misalign = dmem_addr_misalign;
                        // funct3 of 011, 110 and 111 are not RV32I loads
                        trap.illegal_inst = funct3[1:0] == 2'b11 || funct3[2:1] == 2'b11;
                    end
                    rv_pkg::STORE: begin
                        data_wr_req = 1'b1;
                        pc_wr_req   = dmem_ready;
                        trap.store_addr_misalign = dmem_addr_misalign;
                        trap.illegal_inst = funct3[2] || funct3[1:0] == 2'b11;
                    end
                    rv_pkg::SYSTEM: begin
                        if (funct3 == 3'b000) begin
                            case (sys_func)
                                rv_pkg::ECALL:  trap.env_call = 1'b1;
                                rv_pkg::EBREAK: trap.env_break = 1'b1;
                                rv_pkg::MRET: begin
                                    pc_wr_req        = 1'b1;
                                    trap.trap_finish = 1'b1;
                                end
                                default: trap.illegal_inst = 1'b1;
                            endcase
                        end else if (funct3 == 3'b100) begin
                            trap.illegal_inst = 1'b1;
                        end else begin
                            // CSR access, rd gets the old value
                            pc_wr_req  = 1'b1;
                            reg_wr_req = 1'b1;
                            csr_wr_req = 1'b1;
                        end
                    end
                    default: trap.illegal_inst = 1'b1;
                endcase
            end

            rv_pkg::WB: begin
                pc_wr_req  = 1'b1;
                reg_wr_req = 1'b1;
            end

            rv_pkg::TRAP: begin
                pc_wr_req       = 1'b1;
                trap.trap_start = 1'b1;
            end

            default: inst_read = 1'b0;
        endcase
    end

    // A faulting instruction leaves no architectural trace
    assign pc_write   = pc_wr_req & ~trap.trap_pending;
    assign data_read  = data_rd_req & ~trap.trap_pending;
    assign data_write = data_wr_req & ~trap.trap_pending;
    assign reg_write  = reg_wr_req & ~trap.trap_pending;
    assign csr_write  = csr_wr_req & ~trap.trap_pending;

    always_comb begin
        state_nxt = state;
        case (state)
            rv_pkg::FETCH: begin
                if (imem_ready) begin
                    state_nxt = rv_pkg::EXECUTE;
                end
            end
            rv_pkg::EXECUTE: begin
                if (trap.trap_pending) begin
                    state_nxt = rv_pkg::TRAP;
                end else if (opcode == rv_pkg::LOAD) begin
                    if (dmem_ready) begin
                        state_nxt = rv_pkg::WB;
                    end
                end else if (opcode == rv_pkg::STORE) begin
                    if (dmem_ready) begin
                        state_nxt = rv_pkg::FETCH;
                    end
                end else begin
                    state_nxt = rv_pkg::FETCH;
                end
            end
            default: state_nxt = rv_pkg::FETCH;
        endcase
    end

    a_trap_start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        trap.trap_start |=> !trap.trap_start)
        else $error("trap_start held longer than one cycle");

    a_strobes_masked: assert property (@(posedge clk) disable iff (!rst_n)
        trap.trap_pending |-> !(pc_write || reg_write || data_read || data_write || csr_write))
        else $error("state-changing strobe while trap pending");

endmodule

`default_nettype wire

/* logic/lsu_align.sv */
`default_nettype none

module lsu_align (
    input  logic [rv_pkg::xlen-1:0] addr,
    input  rv_pkg::mem_size_e       size,
    output logic                    misalign,
    output logic [3:0]              byte_en
);

    always_comb begin
        misalign = 1'b0;
        byte_en  = 4'b0000;

        case (size)
            rv_pkg::BYTE: begin
                byte_en = 4'b0001 << addr[1:0];
            end
            rv_pkg::HALF: begin
                misalign = addr[0];
                case (addr[1:0])
                    2'b00:   byte_en = 4'b0011;
                    2'b10:   byte_en = 4'b1100;
                    default: byte_en = 4'b0000;
                endcase
            end
            rv_pkg::WORD: begin
                misalign = addr[1:0] != 2'b00;
                if (addr[1:0] == 2'b00) begin
                    byte_en = 4'b1111;
                end
            end
            // Size 11 is caught as illegal by the decoder
            default: begin
                misalign = 1'b0;
                byte_en  = 4'b0000;
            end
        endcase

        a_no_enable_on_misalign: assert (!(misalign && byte_en != 4'b0000))
            else $error("byte enables active on a misaligned access");
    end

endmodule

`default_nettype wire

/* logic/trap_if.sv */
`default_nettype none

interface trap_if;

    // Exception flags, valid in EXECUTE only
    logic illegal_inst;
    logic inst_addr_misalign;
    logic load_addr_misalign;
    logic store_addr_misalign;
    logic env_call;
    logic env_break;

    logic trap_start;
    logic trap_finish;
    logic trap_pending;

    modport source (
        output illegal_inst,
        output inst_addr_misalign,
        output load_addr_misalign,
        output store_addr_misalign,
        output env_call,
        output env_break,
        output trap_start,
        output trap_finish,
        input  trap_pending
    );

    modport sink (
        input  illegal_inst,
        input  inst_addr_misalign,
        input  load_addr_misalign,
        input  store_addr_misalign,
        input  env_call,
        input  env_break,
        input  trap_start,
        input  trap_finish,
        output trap_pending
    );

endinterface

`default_nettype wire

/* logic/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int unsigned xlen = 32;

    localparam logic [xlen-1:0] reset_vector = 32'h0000_0100;

    // RV32I base opcodes, inst[6:0]
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        FENCE  = 7'b0001111,
        SYSTEM = 7'b1110011
    } opcode_e;

    // inst[31:20] of SYSTEM with funct3 zero
    typedef enum logic [11:0] {
        ECALL  = 12'h000,
        EBREAK = 12'h001,
        MRET   = 12'h302
    } sys_func_e;

    typedef enum logic [11:0] {
        MTVEC  = 12'h305,
        MEPC   = 12'h341,
        MCAUSE = 12'h342,
        MTVAL  = 12'h343
    } csr_addr_e;

    typedef enum logic [1:0] {
        FETCH,
        EXECUTE,
        WB,
        TRAP
    } ctrl_state_e;

    // Same encoding as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } mem_size_e;

    typedef enum logic [3:0] {
        INST_MISALIGN  = 4'd0,
        ILLEGAL        = 4'd2,
        BREAKPOINT     = 4'd3,
        LOAD_MISALIGN  = 4'd4,
        STORE_MISALIGN = 4'd6,
        ECALL_M        = 4'd11
    } trap_cause_e;

endpackage

`default_nettype wire
